//--- ringCache_macros.svh
// geometry, ring slot codes and snoop queue depth
// shared by the cache RTL and its testbench
`ifndef RINGCACHE_MACROS_SVH
`define RINGCACHE_MACROS_SVH

// cache geometry
`define numLines 128
`define lineWords 8

// highest valid ring source id
`define numCores 4

// pending snoop entries
`define snoopDepth 8

// ring slot type codes
`define slotAddress 4'd1
`define slotWriteData 4'd2
`define slotGrantExclusive 4'd3

`endif

//--- logic/ringCachePkg.sv
// vector typedefs for words, addresses and ring ids
// line state and controller state enums
package ringCachePkg;

  typedef logic [31:0] wordT;       // data word or ring payload
  typedef logic [30:0] cpuAddrT;    // cpu word address
  typedef logic [20:0] tagT;        // aq[30:10]
  typedef logic [6:0]  lineIndexT;  // aq[9:3]
  typedef logic [2:0]  wordSelT;    // aq[2:0]
  typedef logic [9:0]  dataAddrT;   // {line index, word}
  typedef logic [3:0]  coreIdT;
  typedef logic [3:0]  slotTypeT;

  // encoding 2'd2 left free for an exclusive clean state
  typedef enum logic [1:0] {
    INVALID  = 2'd0,
    SHARED   = 2'd1,
    MODIFIED = 2'd3
  } lineStateE;

  typedef enum logic [3:0] {
    ctrlIdle,
    ctrlSnoopCheck,     // registered lookup of the snooped line
    ctrlRequestToken,   // read request waits for the token
    ctrlFlushToken,     // snoop flush waits for the token
    ctrlSendData,
    ctrlSendWriteAddr
  } ctrlStateE;

endpackage

//--- logic/lineStateArray.sv
// tag and line state arrays of the data cache
// registered request port, combinational snoop port
`timescale 1ns/1ps
`include "ringCache_macros.svh"

module lineStateArray
  import ringCachePkg::*;
(
  input  logic      clock,
  input  logic      reset,
  // request port, driven by the controller
  input  lineIndexT reqIndex,
  input  tagT       newTag,
  input  lineStateE newState,
  input  logic      writeEnable,
  output tagT       reqTag,
  output lineStateE reqState,
  // snoop lookup from the ring
  input  lineIndexT snoopIndex,
  output tagT       snoopTag,
  output lineStateE snoopState
);

  tagT       tags   [`numLines];
  lineStateE states [`numLines];

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      tags[reqIndex] <= newTag;
    end
    reqTag <= tags[reqIndex];  // read before write
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `numLines; i++) begin
        states[i] <= INVALID;
      end
      reqState <= INVALID;
    end else begin
      if (writeEnable) begin
        states[reqIndex] <= newState;
      end
      reqState <= states[reqIndex];
    end
  end

  // snoop filter needs the answer in the slot cycle
  assign snoopTag   = tags[snoopIndex];
  assign snoopState = states[snoopIndex];

endmodule

//--- logic/snoopQueue.sv
// snoop filter for read address slots of other cores
// plus a small FIFO of snoops waiting for the controller
`timescale 1ns/1ps
`include "ringCache_macros.svh"

module snoopQueue
  import ringCachePkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  coreIdT    whichCore,
  input  wordT      ringIn,
  input  slotTypeT  slotTypeIn,
  input  coreIdT    sourceIn,
  input  tagT       snoopTag,
  input  lineStateE snoopState,
  output lineIndexT snoopIndex,
  input  logic      snoopPop,
  output logic      snoopEmpty,
  output wordT      snoopHead
);

  localparam int ptrBits = $clog2(`snoopDepth);
  localparam logic [ptrBits:0] depthCount = `snoopDepth;

  wordT               entries [`snoopDepth];
  logic [ptrBits-1:0] writePtr;
  logic [ptrBits-1:0] readPtr;
  logic [ptrBits:0]   count;
  logic               isReadSlot;
  logic               fromOtherCore;
  logic               lineInUse;
  logic               full;
  logic               push;
  logic               pop;

  assign snoopIndex = ringIn[6:0];
  assign isReadSlot = (slotTypeIn == `slotAddress) && ringIn[28];
  assign fromOtherCore = (sourceIn != whichCore) && (sourceIn != '0) &&
                         (sourceIn <= coreIdT'(`numCores));

  // plain read only matters when we hold dirty data
  assign lineInUse = (snoopTag == ringIn[27:7]) &&
                     ((!ringIn[29] && snoopState == MODIFIED) ||
                      (ringIn[29] && snoopState != INVALID));

  assign full = (count == depthCount);
  assign push = isReadSlot && fromOtherCore && lineInUse && !full;  // dropped when full
  assign pop  = snoopPop && !snoopEmpty;

  always_ff @(posedge clock) begin
    if (push) begin
      entries[writePtr] <= ringIn;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
    end else begin
      if (push) writePtr <= writePtr + 1'b1;
      if (pop) readPtr <= readPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign snoopEmpty = (count == '0);
  assign snoopHead  = entries[readPtr];

endmodule

//--- logic/lineDataRam.sv
// data memory of the cache, 128 lines of 8 words
// port A for cpu access and line readout, second port for fills
`timescale 1ns/1ps
`include "ringCache_macros.svh"

module lineDataRam
  import ringCachePkg::*;
(
  input  logic     clock,
  // cpu and flush port
  input  dataAddrT portAddr,
  input  wordT     portWriteData,
  input  logic     portWrite,
  output wordT     portReadData,
  // fill port, write only
  input  dataAddrT fillAddr,
  input  wordT     fillData,
  input  logic     fillWrite
);

  wordT mem [`numLines * `lineWords];

  always_ff @(posedge clock) begin
    if (portWrite) begin
      mem[portAddr] <= portWriteData;
    end
    if (fillWrite) begin
      mem[fillAddr] <= fillData;
    end
    portReadData <= mem[portAddr];  // old data on a same-cycle write
  end

endmodule

//--- logic/missControl.sv
// cache controller: request arbitration, hit and miss handling
// ring slot emission for requests, write-backs and snoop flushes
// read data return tracking for line fills and GrantExclusive
`timescale 1ns/1ps
`include "ringCache_macros.svh"

module missControl
  import ringCachePkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  coreIdT    whichCore,
  // cpu side
  input  cpuAddrT   aq,
  input  logic      read,
  input  wordT      wq,
  input  logic      selDCache,
  output logic      done,
  output logic      wrq,
  output logic      rwq,
  // ring side
  input  wordT      ringIn,
  input  slotTypeT  slotTypeIn,
  input  coreIdT    sourceIn,
  input  coreIdT    rdDest,
  input  wordT      rdReturn,
  output wordT      ringOut,
  output slotTypeT  slotTypeOut,
  output logic      driveRing,
  output logic      wantsToken,
  input  logic      acquireToken,
  // snoop queue
  input  logic      snoopEmpty,
  input  wordT      snoopHead,
  output logic      snoopPop,
  // line state array
  output lineIndexT reqIndex,
  output tagT       newTag,
  output lineStateE newState,
  output logic      stateWrite,
  input  tagT       reqTag,
  input  lineStateE reqState,
  // data memory
  output dataAddrT  portAddr,
  output wordT      portWriteData,
  output logic      portWrite,
  input  wordT      portReadData,
  output dataAddrT  fillAddr,
  output wordT      fillData,
  output logic      fillWrite
);

  typedef enum logic [1:0] {
    waitNone,
    waitFill,     // counting returning words
    waitGap,      // one spare cycle so port A sees the filled line
    waitResolve
  } waitStateE;

  ctrlStateE state;
  waitStateE waitState;
  wordT      readRequest;
  wordT      writeAddrSlot;
  lineIndexT flushLine;
  logic      doFlush;
  wordSelT   wordCount;   // word on the ring in ctrlSendData
  wordSelT   fillCount;
  logic      delayedSel;
  logic      aqLookup;    // last lookup and readout used aq
  logic      aqAddressed;
  logic      takeSnoop;
  logic      takeAq;
  logic      takeResolve;
  logic      hitTag;
  logic      readHit;
  logic      writeHit;
  logic      missStart;
  logic      alreadyHas;
  logic      snoopMatch;
  logic      grantSeen;

  // idle arbitration, snoops first
  assign takeSnoop   = (state == ctrlIdle) && !snoopEmpty;
  assign takeAq      = (state == ctrlIdle) && snoopEmpty && delayedSel && aqLookup &&
                       (waitState == waitNone);
  assign takeResolve = (state == ctrlIdle) && snoopEmpty && aqLookup &&
                       (waitState == waitResolve);

  assign hitTag     = (reqTag == aq[30:10]);
  assign readHit    = takeAq && read && hitTag && (reqState != INVALID);
  assign writeHit   = takeAq && !read && hitTag && (reqState == MODIFIED);
  assign missStart  = takeAq && !readHit && !writeHit;
  assign alreadyHas = !read && hitTag && (reqState == SHARED);  // only ownership needed

  assign done = readHit || writeHit || takeResolve;
  assign wrq  = readHit || (takeResolve && read);
  assign rwq  = writeHit || (takeResolve && !read);

  assign snoopMatch = (state == ctrlSnoopCheck) && (reqTag == snoopHead[27:7]) &&
                      (reqState != INVALID);
  assign snoopPop   = (state == ctrlSnoopCheck);

  // line state port
  assign reqIndex   = (takeSnoop || state == ctrlSnoopCheck) ? snoopHead[6:0] : aq[9:3];
  assign newTag     = (state == ctrlSnoopCheck) ? reqTag : aq[30:10];
  assign stateWrite = missStart || takeResolve || snoopMatch;

  always_comb begin
    if (snoopMatch) newState = snoopHead[29] ? INVALID : SHARED;
    else if (takeResolve) newState = read ? SHARED : MODIFIED;
    else newState = INVALID;  // line unusable while the miss is open
  end

  // port A address, one cycle ahead of the word on the ring
  always_comb begin
    case (state)
      ctrlSnoopCheck:   portAddr = {snoopHead[6:0], 3'd0};
      ctrlRequestToken: portAddr = {flushLine, 3'd0};
      ctrlFlushToken:   portAddr = {flushLine, acquireToken ? 3'd1 : 3'd0};
      ctrlSendData:     portAddr = {flushLine, wordSelT'(wordCount + 3'd1)};
      default:          portAddr = aq[9:0];
    endcase
  end

  assign aqAddressed   = !takeSnoop && (state == ctrlIdle || state == ctrlSendWriteAddr);
  assign portWriteData = wq;
  assign portWrite     = writeHit || (takeResolve && !read);

  // ring output
  assign wantsToken = (state == ctrlRequestToken) || (state == ctrlFlushToken);
  assign driveRing  = (wantsToken && acquireToken) || (state == ctrlSendData) ||
                      (state == ctrlSendWriteAddr);

  always_comb begin
    case (state)
      ctrlRequestToken: begin
        ringOut     = readRequest;
        slotTypeOut = `slotAddress;
      end
      ctrlFlushToken, ctrlSendData: begin
        ringOut     = portReadData;
        slotTypeOut = `slotWriteData;
      end
      ctrlSendWriteAddr: begin
        ringOut     = writeAddrSlot;
        slotTypeOut = `slotAddress;
      end
      default: begin
        ringOut     = '0;
        slotTypeOut = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ctrlIdle;
      doFlush   <= 1'b0;
      wordCount <= '0;
    end else begin
      case (state)
        ctrlIdle: begin
          if (takeSnoop) begin
            state <= ctrlSnoopCheck;
          end else if (missStart) begin
            state   <= ctrlRequestToken;
            doFlush <= (reqState == MODIFIED);  // dirty victim of another tag
          end
        end
        ctrlSnoopCheck: begin
          if (snoopMatch && reqState == MODIFIED) state <= ctrlFlushToken;
          else state <= ctrlIdle;
        end
        ctrlRequestToken: begin
          if (acquireToken) begin
            wordCount <= '0;
            state     <= doFlush ? ctrlSendData : ctrlIdle;
          end
        end
        ctrlFlushToken: begin
          if (acquireToken) begin
            wordCount <= 3'd1;  // word 0 went out with the token
            state     <= ctrlSendData;
          end
        end
        ctrlSendData: begin
          wordCount <= wordCount + 1'b1;
          if (wordCount == wordSelT'(`lineWords - 1)) state <= ctrlSendWriteAddr;
        end
        ctrlSendWriteAddr: state <= ctrlIdle;
        default:           state <= ctrlIdle;
      endcase
    end
  end

  // slot payloads
  always_ff @(posedge clock) begin
    if (missStart) begin
      readRequest   <= {1'b0, alreadyHas, !read, 1'b1, aq[30:3]};
      writeAddrSlot <= {4'b0000, reqTag, aq[9:3]};  // victim line
      flushLine     <= aq[9:3];
    end else if (state == ctrlSnoopCheck) begin
      writeAddrSlot <= {4'b0010, snoopHead[27:0]};  // requested flush
      flushLine     <= snoopHead[6:0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      delayedSel <= 1'b0;
      aqLookup   <= 1'b0;
    end else begin
      delayedSel <= selDCache && !done;
      aqLookup   <= aqAddressed && !stateWrite;
    end
  end

  // read data return tracking
  assign grantSeen = (slotTypeIn == `slotGrantExclusive) && (sourceIn == whichCore) &&
                     (ringIn[27:0] == aq[30:3]);
  assign fillWrite = (waitState == waitFill) && (rdDest == whichCore);
  assign fillAddr  = {aq[9:3], fillCount};
  assign fillData  = rdReturn;

  always_ff @(posedge clock) begin
    if (reset) begin
      waitState <= waitNone;
      fillCount <= '0;
    end else begin
      case (waitState)
        waitNone: begin
          if (missStart) begin
            waitState <= waitFill;
            fillCount <= '0;
          end
        end
        waitFill: begin
          if (grantSeen) begin
            waitState <= waitGap;
          end else if (fillWrite) begin
            fillCount <= fillCount + 1'b1;
            if (fillCount == wordSelT'(`lineWords - 1)) waitState <= waitGap;
          end
        end
        waitGap:     waitState <= waitResolve;
        waitResolve: if (takeResolve) waitState <= waitNone;
        default:     waitState <= waitNone;
      endcase
    end
  end

endmodule

//--- logic/coherentDCache.sv
// coherent data cache of one core on the slotted ring
// line state arrays, snoop queue, data memory and controller
`timescale 1ns/1ps

module coherentDCache
  import ringCachePkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  coreIdT   whichCore,
  // cpu side
  input  cpuAddrT  aq,
  input  logic     read,
  input  wordT     wq,
  input  logic     selDCache,
  output wordT     rqDCache,
  output logic     wrq,
  output logic     rwq,
  output logic     done,
  // ring in, plus the separate read data return
  input  wordT     ringIn,
  input  slotTypeT slotTypeIn,
  input  coreIdT   sourceIn,
  input  wordT     rdReturn,
  input  coreIdT   rdDest,
  // ring out
  output wordT     ringOut,
  output slotTypeT slotTypeOut,
  output coreIdT   sourceOut,
  output logic     driveRing,
  output logic     wantsToken,
  input  logic     acquireToken
);

  lineIndexT reqIndex;
  tagT       newTag;
  lineStateE newState;
  logic      stateWrite;
  tagT       reqTag;
  lineStateE reqState;
  lineIndexT snoopIndex;
  tagT       snoopTag;
  lineStateE snoopState;
  logic      snoopPop;
  logic      snoopEmpty;
  wordT      snoopHead;
  dataAddrT  portAddr;
  wordT      portWriteData;
  logic      portWrite;
  dataAddrT  fillAddr;
  wordT      fillData;
  logic      fillWrite;

  assign sourceOut = whichCore;

  lineStateArray stateArray (
    .clock(clock), .reset(reset),
    .reqIndex(reqIndex), .newTag(newTag), .newState(newState), .writeEnable(stateWrite),
    .reqTag(reqTag), .reqState(reqState),
    .snoopIndex(snoopIndex), .snoopTag(snoopTag), .snoopState(snoopState)
  );

  snoopQueue snoops (
    .clock(clock), .reset(reset), .whichCore(whichCore),
    .ringIn(ringIn), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .snoopTag(snoopTag), .snoopState(snoopState), .snoopIndex(snoopIndex),
    .snoopPop(snoopPop), .snoopEmpty(snoopEmpty), .snoopHead(snoopHead)
  );

  // port A read data doubles as the cpu read queue input
  lineDataRam dataRam (
    .clock(clock),
    .portAddr(portAddr), .portWriteData(portWriteData), .portWrite(portWrite),
    .portReadData(rqDCache),
    .fillAddr(fillAddr), .fillData(fillData), .fillWrite(fillWrite)
  );

  missControl control (
    .clock(clock), .reset(reset), .whichCore(whichCore),
    .aq(aq), .read(read), .wq(wq), .selDCache(selDCache),
    .done(done), .wrq(wrq), .rwq(rwq),
    .ringIn(ringIn), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .rdDest(rdDest), .rdReturn(rdReturn),
    .ringOut(ringOut), .slotTypeOut(slotTypeOut), .driveRing(driveRing),
    .wantsToken(wantsToken), .acquireToken(acquireToken),
    .snoopEmpty(snoopEmpty), .snoopHead(snoopHead), .snoopPop(snoopPop),
    .reqIndex(reqIndex), .newTag(newTag), .newState(newState), .stateWrite(stateWrite),
    .reqTag(reqTag), .reqState(reqState),
    .portAddr(portAddr), .portWriteData(portWriteData), .portWrite(portWrite),
    .portReadData(rqDCache),
    .fillAddr(fillAddr), .fillData(fillData), .fillWrite(fillWrite)
  );

endmodule

//--- verification/ringAgent.sv
// ring, token and memory controller model for the cache testbench
// records emitted slots, answers read requests, applies write-backs
// injects snoop read slots from core 3
`timescale 1ns/1ps
`include "ringCache_macros.svh"

module ringAgent
  import ringCachePkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  coreIdT   whichCore,
  input  wordT     ringOut,
  input  slotTypeT slotTypeOut,
  input  logic     driveRing,
  input  logic     wantsToken,
  output logic     acquireToken,
  output wordT     ringIn,
  output slotTypeT slotTypeIn,
  output coreIdT   sourceIn,
  output wordT     rdReturn,
  output coreIdT   rdDest,
  input  logic     injectValid,
  input  wordT     injectWord
);

  wordT        mem [cpuAddrT];
  slotTypeT    recTypes [0:1023];  // every slot the cache emitted
  wordT        recWords [0:1023];
  int          recCount = 0;
  wordT        wbData [0:7];
  int          wbCount = 0;
  logic [27:0] reqLine;
  logic        hasData;
  logic        pendingReq = 1'b0;
  logic        respGrant = 1'b0;
  int          respIdx = -1;      // next fill word, -1 when idle
  logic        injectPending = 1'b0;
  int          tokenDelay = 2;
  integer      seed = 32'h4bd9_a927;

  // untouched memory words come from a pattern over the full address
  function automatic wordT memWord(cpuAddrT addr);
    if (mem.exists(addr)) return mem[addr];
    return (32'(addr) * 32'h9e37_79b9) ^ 32'h3c5a_0f96;
  endfunction

  initial begin
    acquireToken = 1'b0;
    ringIn       = '0;
    slotTypeIn   = '0;
    sourceIn     = '0;
    rdReturn     = '0;
    rdDest       = '0;
  end

  always @(posedge clock) begin
    if (injectValid) injectPending = 1'b1;
    if (pendingReq && !driveRing) begin  // answer once the burst is over
      pendingReq = 1'b0;
      if (hasData) respGrant = 1'b1;
      else respIdx = 0;
    end
    if (driveRing) begin
      recTypes[recCount] = slotTypeOut;
      recWords[recCount] = ringOut;
      recCount++;
      if (slotTypeOut == `slotWriteData) begin
        wbData[wbCount % 8] = ringOut;
        wbCount++;
      end else if (ringOut[28]) begin
        pendingReq = 1'b1;
        reqLine    = ringOut[27:0];
        hasData    = ringOut[30];
      end else begin
        // write address closes a write-back or flush
        for (int i = 0; i < `lineWords; i++) begin
          mem[{ringOut[27:0], 3'(i)}] = wbData[i];
        end
        wbCount = 0;
      end
    end
  end

  always @(negedge clock) begin
    ringIn     <= '0;
    slotTypeIn <= '0;
    sourceIn   <= '0;
    rdDest     <= '0;
    rdReturn   <= '0;
    if (respGrant) begin
      ringIn     <= {4'b0000, reqLine};
      slotTypeIn <= `slotGrantExclusive;
      sourceIn   <= whichCore;
      respGrant = 1'b0;
    end else if (injectPending) begin
      ringIn     <= injectWord;
      slotTypeIn <= `slotAddress;
      sourceIn   <= 4'd3;
      injectPending = 1'b0;
    end
    if (respIdx >= 0 && ($random(seed) & 3) != 0) begin  // random gaps
      rdDest   <= whichCore;
      rdReturn <= memWord({reqLine, 3'(respIdx)});
      respIdx = (respIdx == `lineWords - 1) ? -1 : respIdx + 1;
    end
    if (reset) begin
      acquireToken <= 1'b0;
    end else if (acquireToken) begin
      acquireToken <= 1'b0;  // token held for one slot only
    end else if (wantsToken) begin
      if (tokenDelay == 0) begin
        acquireToken <= 1'b1;
        tokenDelay = $random(seed) & 3;
      end else begin
        tokenDelay--;
      end
    end
  end

endmodule

//--- verification/coherentDCacheTb.sv
// testbench for the coherent data cache
// clock, reset, cpu stimulus, line reference model, compare tasks, watchdog
`timescale 1ns/1ps
`include "ringCache_macros.svh"

module coherentDCacheTb
  import ringCachePkg::*;
();

  localparam int numStores = 10;
  localparam int numRandom = 40;
  localparam int numOps = 2 * numStores + 12 + numRandom;  // directed, snoops and random

  logic      clock;
  logic      reset;
  cpuAddrT   aq;
  logic      read;
  wordT      wq;
  logic      selDCache;
  wordT      rqDCache;
  logic      wrq, rwq, done;
  wordT      ringIn, ringOut, rdReturn, injectWord;
  slotTypeT  slotTypeIn, slotTypeOut;
  coreIdT    sourceIn, sourceOut, rdDest;
  logic      driveRing, wantsToken, acquireToken, injectValid;
  integer    seed;
  int        errorCount = 0;
  tagT       expTag [`numLines];
  lineStateE expState [`numLines];
  wordT      expData [`numLines][`lineWords];
  slotTypeT  expTypes [$];
  wordT      expWords [$];
  cpuAddrT   addr;
  cpuAddrT   addrs [numStores];
  logic [2:0] pick;

  coherentDCache UUT (
    .clock(clock), .reset(reset), .whichCore(4'd2),
    .aq(aq), .read(read), .wq(wq), .selDCache(selDCache),
    .rqDCache(rqDCache), .wrq(wrq), .rwq(rwq), .done(done),
    .ringIn(ringIn), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .rdReturn(rdReturn), .rdDest(rdDest),
    .ringOut(ringOut), .slotTypeOut(slotTypeOut), .sourceOut(sourceOut),
    .driveRing(driveRing), .wantsToken(wantsToken), .acquireToken(acquireToken)
  );

  ringAgent agent (
    .clock(clock), .reset(reset), .whichCore(4'd2),
    .ringOut(ringOut), .slotTypeOut(slotTypeOut), .driveRing(driveRing),
    .wantsToken(wantsToken), .acquireToken(acquireToken),
    .ringIn(ringIn), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .rdReturn(rdReturn), .rdDest(rdDest),
    .injectValid(injectValid), .injectWord(injectWord)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    #(numOps * 200 * 8);
    $display("timeout: a cpu access or ring transfer never finished");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  task automatic stopRun(string reason);
    errorCount++;
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkWord(string name, wordT got, wordT exp);
    if (got !== exp) stopRun($sformatf("error at %0t: %s got %h expected %h",
                                       $time, name, got, exp));
  endtask

  task automatic checkState(string name, lineStateE got, lineStateE exp);
    if (got !== exp) stopRun($sformatf("error at %0t: %s got %s expected %s",
                                       $time, name, got.name(), exp.name()));
  endtask

  task automatic checkSlot(string name, slotTypeT gotType, wordT got,
                           slotTypeT expType, wordT exp);
    if (gotType !== expType || got !== exp) begin
      stopRun($sformatf("error at %0t: %s got %h:%h expected %h:%h",
                        $time, name, gotType, got, expType, exp));
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) stopRun($sformatf("error at %0t: %s got %b expected %b",
                                       $time, name, got, exp));
  endtask

  task automatic checkCore(string name, coreIdT got, coreIdT exp);
    if (got !== exp) stopRun($sformatf("error at %0t: %s got %0d expected %0d",
                                       $time, name, got, exp));
  endtask

  task automatic compareSlots(int start);
    if (agent.recCount - start != expTypes.size()) begin
      stopRun($sformatf("error at %0t: ring slot count got %0d expected %0d",
                        $time, agent.recCount - start, expTypes.size()));
    end
    for (int i = 0; i < expTypes.size(); i++) begin
      checkSlot("ringOut", agent.recTypes[start + i], agent.recWords[start + i],
                expTypes[i], expWords[i]);
    end
  endtask

  function automatic cpuAddrT randAddr();
    tagT       tag;
    lineIndexT idx;
    wordSelT   off;
    tag = tagT'($random(seed) & 3);  // few tags, many conflicts
    idx = lineIndexT'($random(seed) & 15);
    off = wordSelT'($random(seed));
    return {tag, idx, off};
  endfunction

  task automatic cpuAccess(cpuAddrT a, logic isRead, wordT data);
    lineIndexT idx;
    tagT       tag;
    logic      match, hit, dirtyVictim;
    int        start;
    wordT      got;
    lineStateE seen, prior;
    idx = a[9:3];
    tag = a[30:10];
    match = (expTag[idx] === tag) && (expState[idx] != INVALID);
    hit = match && (isRead || expState[idx] == MODIFIED);
    dirtyVictim = !hit && !match && (expState[idx] == MODIFIED);
    prior = match ? (isRead ? SHARED : expState[idx]) : INVALID;
    expTypes.delete();
    expWords.delete();
    if (!hit) begin
      expTypes.push_back(`slotAddress);
      expWords.push_back({1'b0, !isRead && match, !isRead, 1'b1, a[30:3]});
      if (dirtyVictim) begin  // victim goes out after the request
        for (int i = 0; i < `lineWords; i++) begin
          expTypes.push_back(`slotWriteData);
          expWords.push_back(expData[idx][i]);
        end
        expTypes.push_back(`slotAddress);
        expWords.push_back({4'b0000, expTag[idx], idx});
      end
    end
    start = agent.recCount;
    @(negedge clock);
    aq = a;
    read = isRead;
    wq = data;
    selDCache = 1'b1;
    do @(negedge clock); while (!done);
    got = rqDCache;
    checkFlag("wrq", wrq, isRead);
    checkFlag("rwq", rwq, !isRead);
    selDCache = 1'b0;  // aq and wq stay until the next access
    if (agent.recCount == start) seen = isRead ? SHARED : MODIFIED;
    else if (agent.recWords[start][30]) seen = SHARED;
    else seen = INVALID;
    checkState("line state", seen, prior);
    compareSlots(start);
    if (dirtyVictim) begin
      for (int i = 0; i < `lineWords; i++) begin
        checkWord("memory after write-back", agent.memWord({expTag[idx], idx, 3'(i)}),
                  expData[idx][i]);
      end
    end
    if (!hit && !match) begin
      for (int i = 0; i < `lineWords; i++) expData[idx][i] = agent.memWord({tag, idx, 3'(i)});
    end
    if (!hit) begin
      expTag[idx] = tag;
      expState[idx] = isRead ? SHARED : MODIFIED;
    end
    if (isRead) checkWord("rqDCache", got, expData[idx][a[2:0]]);
    else expData[idx][a[2:0]] = data;
  endtask

  task automatic snoopLine(cpuAddrT a, logic exclusive);
    lineIndexT idx;
    tagT       tag;
    logic      match, flush;
    int        start;
    idx = a[9:3];
    tag = a[30:10];
    match = (expTag[idx] === tag) &&
            (exclusive ? expState[idx] != INVALID : expState[idx] == MODIFIED);
    flush = match && (expState[idx] == MODIFIED);
    expTypes.delete();
    expWords.delete();
    if (flush) begin
      for (int i = 0; i < `lineWords; i++) begin
        expTypes.push_back(`slotWriteData);
        expWords.push_back(expData[idx][i]);
      end
      expTypes.push_back(`slotAddress);
      expWords.push_back({4'b0010, a[30:3]});
    end
    start = agent.recCount;
    @(negedge clock);
    injectWord = {2'b00, exclusive, 1'b1, a[30:3]};
    injectValid = 1'b1;
    @(negedge clock);
    injectValid = 1'b0;
    if (flush) begin
      while (agent.recCount < start + `lineWords + 1) @(negedge clock);
    end
    repeat (6) @(negedge clock);  // let the controller return to idle
    compareSlots(start);
    if (flush) begin
      for (int i = 0; i < `lineWords; i++) begin
        checkWord("memory after flush", agent.memWord({tag, idx, 3'(i)}), expData[idx][i]);
      end
    end
    if (match) expState[idx] = exclusive ? INVALID : SHARED;
  endtask

  // a slot may only go out with the token or inside its burst
  always @(posedge clock) begin
    if (!reset && wantsToken && !acquireToken && driveRing) begin
      stopRun("driveRing high while the cache still waits for the token");
    end
    if (!reset && driveRing) checkCore("sourceOut", sourceOut, 4'd2);
  end

  initial begin
    seed = 32'h4bd9_a927;
    reset = 1'b1;
    aq = '0;
    read = 1'b0;
    wq = '0;
    selDCache = 1'b0;
    injectValid = 1'b0;
    injectWord = '0;
    for (int i = 0; i < `numLines; i++) expState[i] = INVALID;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    checkFlag("wantsToken", wantsToken, 1'b0);
    checkFlag("driveRing", driveRing, 1'b0);
    checkFlag("done", done, 1'b0);
    checkFlag("wrq", wrq, 1'b0);
    checkFlag("rwq", rwq, 1'b0);
    addr = randAddr();
    cpuAccess(addr, 1'b1, '0);   // miss
    cpuAccess(addr, 1'b1, '0);   // hit, quiet ring
    for (int i = 0; i < numStores; i++) begin
      addrs[i] = randAddr();
      cpuAccess(addrs[i], 1'b0, $random(seed));
    end
    for (int i = 0; i < numStores; i++) cpuAccess(addrs[i], 1'b1, '0);
    addr = {21'd9, 7'd40, 3'd2};  // store onto a shared line
    cpuAccess(addr, 1'b1, '0);
    cpuAccess(addr, 1'b0, $random(seed));
    cpuAccess({21'd5, 7'd20, 3'd1}, 1'b0, $random(seed));
    cpuAccess({21'd6, 7'd20, 3'd4}, 1'b1, '0);  // dirty victim
    addr = {21'd7, 7'd30, 3'd3};
    cpuAccess(addr, 1'b0, $random(seed));
    snoopLine(addr, 1'b0);
    cpuAccess(addr, 1'b1, '0);
    cpuAccess(addr, 1'b0, $random(seed));
    snoopLine(addr, 1'b1);
    cpuAccess(addr, 1'b1, '0);
    for (int i = 0; i < numRandom; i++) begin
      pick = 3'($random(seed));
      if (pick == 3'd0) snoopLine(randAddr(), 1'($random(seed)));
      else cpuAccess(randAddr(), pick[0], $random(seed));
    end
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
logic/ringCachePkg.sv
logic/lineStateArray.sv
logic/snoopQueue.sv
logic/lineDataRam.sv
logic/missControl.sv
logic/coherentDCache.sv
verification/ringAgent.sv
verification/coherentDCacheTb.sv
